/* logic/ntt_masked_pkg.sv */
// Shared modulus, widths, opcode enum and payload structs, imported by every masked BFU module
package ntt_masked_pkg;

    // ========================================
    // Modulus and widths
    // ========================================

    // ML-DSA prime q = 2^23 - 2^13 + 1
    localparam logic [22:0] MLDSA_Q = 23'd8380417;

    // Width of one arithmetic share, shares are summed modulo 2^SHARE_WIDTH
    localparam int SHARE_WIDTH = 46;

    // Width of the wide random word delivered every cycle
    localparam int RND_WIDTH = 46;

    // The narrow random words come as a small array
    localparam int RND_WORDS = 4;
    localparam int RND_WORD_WIDTH = 14;

    // ========================================
    // Opcodes and payload types
    // ========================================

    // Butterfly operation, add gives u+v and sub gives u-v, both mod q
    typedef enum logic {
        BFU_ADD = 1'b0,
        BFU_SUB = 1'b1
    } bfu_op_e;

    // One coefficient split into two arithmetic shares
    typedef struct packed {
        logic [SHARE_WIDTH-1:0] share0;
        logic [SHARE_WIDTH-1:0] share1;
    } masked_word_t;

    // Request accepted from upstream, one per valid cycle
    typedef struct packed {
        bfu_op_e      op;
        masked_word_t u;
        masked_word_t v;
    } bfu_req_t;

    // Result handed to downstream
    typedef struct packed {
        masked_word_t result;
    } bfu_rsp_t;

    // Fresh randomness for one cycle of the datapath
    typedef struct packed {
        logic [RND_WORDS-1:0][RND_WORD_WIDTH-1:0] rnd14;
        logic [RND_WIDTH-1:0]                     rnd_wide;
    } mask_rnd_t;

endpackage

/* logic/masked_share_adder.sv */
// Registered share-wise adder for two masked operands, refreshing the shares with one random word
`timescale 1ns/1ps

module masked_share_adder #(
    parameter int WIDTH = ntt_masked_pkg::SHARE_WIDTH
) (
    input  logic                         clk,
    input  logic                         rst,
    input  ntt_masked_pkg::masked_word_t x,
    input  ntt_masked_pkg::masked_word_t y,
    input  logic [WIDTH-1:0]             r,
    output ntt_masked_pkg::masked_word_t s
);

    // Share-wise sums before the refresh
    logic [WIDTH-1:0] sum0;
    logic [WIDTH-1:0] sum1;

    // ========================================
    // Share-wise addition
    // ========================================

    // Each share pair is added on its own, so the two shares never meet here
    // All arithmetic wraps modulo 2^WIDTH, which keeps the represented sum intact
    always_comb begin
        sum0 = x.share0 + y.share0;
        sum1 = x.share1 + y.share1;
    end

    // The random word goes into share0 and comes out of share1.
    // The represented value x+y is unchanged, only the split moves
    always_ff @(posedge clk) begin
        if (rst) begin
            s.share0 <= '0;
            s.share1 <= '0;
        end else begin
            s.share0 <= sum0 + r;
            s.share1 <= sum1 - r;
        end
    end

endmodule

/* logic/masked_mod_reduce.sv */
// Six-stage pipeline that takes a masked value below 2q and returns fresh shares of it mod q
`timescale 1ns/1ps

module masked_mod_reduce #(
    parameter int WIDTH = ntt_masked_pkg::SHARE_WIDTH
) (
    input  logic                         clk,
    input  logic                         rst,
    input  ntt_masked_pkg::masked_word_t x,
    input  ntt_masked_pkg::mask_rnd_t    rnd,
    output ntt_masked_pkg::masked_word_t y
);

    import ntt_masked_pkg::*;

    // Modulus at datapath width for the compare and subtract
    localparam logic [WIDTH-1:0] Q_W = WIDTH'(MLDSA_Q);

    // Total width of the narrow random words taken as one vector
    localparam int RND_FLAT_W = RND_WORDS * RND_WORD_WIDTH;

    // Randomness views for the different stages
    logic [RND_FLAT_W-1:0] rnd_flat;
    logic [WIDTH-1:0]      mask_lo;
    logic [WIDTH-1:0]      mask_hi;
    logic [WIDTH-1:0]      mask_wide;

    // Pipeline registers, one per stage
    masked_word_t     st1;
    masked_word_t     st2;
    logic [WIDTH-1:0] val3;
    logic [WIDTH-1:0] val4;
    masked_word_t     st5;
    masked_word_t     st6;

    // ========================================
    // Random word selection
    // ========================================

    // The low and high slices overlap in the middle but differ as words
    assign rnd_flat  = rnd.rnd14;
    assign mask_lo   = rnd_flat[WIDTH-1:0];
    assign mask_hi   = rnd_flat[RND_FLAT_W-1 -: WIDTH];
    assign mask_wide = WIDTH'(rnd.rnd_wide);

    // ========================================
    // Pipeline
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            st1  <= '0;
            st2  <= '0;
            val3 <= '0;
            val4 <= '0;
            st5  <= '0;
            st6  <= '0;
        end else begin
            // Stage 1 moves the split by the wide random word
            st1.share0 <= x.share0 + mask_wide;
            st1.share1 <= x.share1 - mask_wide;

            // Stage 2 moves it again, now with the narrow words
            st2.share0 <= st1.share0 + mask_lo;
            st2.share1 <= st1.share1 - mask_lo;

            // Stage 3 joins the shares into the plain value mod 2^WIDTH
            val3 <= st2.share0 + st2.share1;

            // Stage 4 brings a value in [0,2q) down into [0,q)
            if (val3 >= Q_W) begin
                val4 <= val3 - Q_W;
            end else begin
                val4 <= val3;
            end

            // Stage 5 splits the reduced value, share0 is pure randomness
            st5.share0 <= mask_wide;
            st5.share1 <= val4 - mask_wide;

            // Stage 6 refreshes once more so no output share equals a stage 5 word
            st6.share0 <= st5.share0 + mask_hi;
            st6.share1 <= st5.share1 - mask_hi;
        end
    end

    // The last stage drives the output directly
    assign y = st6;

endmodule

/* logic/masked_bfu_add_sub.sv */
// Butterfly add/sub on masked coefficients, seven clocks from request to reduced result
`timescale 1ns/1ps

module masked_bfu_add_sub #(
    parameter int WIDTH = ntt_masked_pkg::SHARE_WIDTH
) (
    input  logic                         clk,
    input  logic                         rst,
    input  ntt_masked_pkg::bfu_req_t     req,
    input  ntt_masked_pkg::mask_rnd_t    rnd,
    output ntt_masked_pkg::masked_word_t res
);

    import ntt_masked_pkg::*;

    localparam logic [WIDTH-1:0] Q_W = WIDTH'(MLDSA_Q);

    // Second operand after the optional negation
    masked_word_t v_int;

    // Share sum between the adder and the reduction
    masked_word_t add_res;

    // ========================================
    // Operand negation
    // ========================================

    // For subtraction the shares of v become (q-v0, -v1).
    // Their sum is q-v, so u-v+q lands in [0,2q) like an addition
    always_comb begin
        v_int = req.v;
        if (req.op == BFU_SUB) begin
            v_int.share0 = Q_W - req.v.share0;
            v_int.share1 = ~req.v.share1 + 1'b1;
        end
    end

    // Share-wise sum, one clock
    masked_share_adder #(
        .WIDTH(WIDTH)
    ) u_adder (
        .clk (clk),
        .rst (rst),
        .x   (req.u),
        .y   (v_int),
        .r   (WIDTH'(rnd.rnd_wide)),
        .s   (add_res)
    );

    // Reduction into [0,q) with remasking, six clocks
    masked_mod_reduce #(
        .WIDTH(WIDTH)
    ) u_reduce (
        .clk (clk),
        .rst (rst),
        .x   (add_res),
        .rnd (rnd),
        .y   (res)
    );

endmodule

/* logic/mask_rnd_source.sv */
// Bank of four LFSRs that supplies new masking randomness to the butterfly every clock
`timescale 1ns/1ps

module mask_rnd_source (
    input  logic                      clk,
    input  logic                      rst,
    output ntt_masked_pkg::mask_rnd_t rnd
);

    import ntt_masked_pkg::*;

    localparam int NUM_LFSR = 4;

    // Distinct nonzero seeds so the four sequences start apart
    localparam logic [NUM_LFSR-1:0][31:0] SEEDS = {
        32'h9e37_79b9, 32'h7f4a_7c15, 32'h1b87_3593, 32'hc2b2_ae35
    };

    logic [NUM_LFSR-1:0][31:0] lfsr;
    logic [63:0]               wide_src;

    // ========================================
    // LFSR bank
    // ========================================

    // Fibonacci form, taps 32, 22, 2 and 1 for a maximal length sequence
    for (genvar i = 0; i < NUM_LFSR; i++) begin : g_lfsr
        always_ff @(posedge clk) begin
            if (rst) begin
                lfsr[i] <= SEEDS[i];
            end else begin
                lfsr[i] <= {lfsr[i][30:0], lfsr[i][31] ^ lfsr[i][21] ^ lfsr[i][1] ^ lfsr[i][0]};
            end
        end

        // Each narrow word mixes the low bits of one LFSR with the top of the next
        assign rnd.rnd14[i] = lfsr[i][RND_WORD_WIDTH-1:0]
                            ^ lfsr[(i + 1) % NUM_LFSR][31 -: RND_WORD_WIDTH];
    end

    // Wide word from pairwise XOR of the registers, cut to the wide width
    assign wide_src     = {lfsr[3] ^ lfsr[1], lfsr[2] ^ lfsr[0]};
    assign rnd.rnd_wide = wide_src[RND_WIDTH-1:0];

endmodule

/* logic/bfu_result_buffer.sv */
// Result FIFO that gives input credits back upstream and only sends while holding output credits
`timescale 1ns/1ps

module bfu_result_buffer #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_en,
    input  ntt_masked_pkg::bfu_rsp_t wr_rsp,
    input  logic                     out_credit,
    output logic                     out_valid,
    output ntt_masked_pkg::bfu_rsp_t out_rsp,
    output logic                     in_credit
);

    import ntt_masked_pkg::*;

    localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int CRED_W = 16;

    // Result storage and its pointers
    bfu_rsp_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // Items held and credits granted by downstream
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] out_credits;
    logic              pop;

    // Circular advance, also correct for a depth that is not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // ========================================
    // Output and credit return
    // ========================================

    // A result leaves when one is held and downstream has room for it
    assign pop       = (count != '0) && (out_credits != '0);
    assign out_valid = pop;
    assign out_rsp   = mem[rd_ptr];

    // The freed slot goes straight back to upstream as a credit
    assign in_credit = pop;

    // Tail write of a finished butterfly result
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_rsp;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            out_credits <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end

            // Upstream credits keep writes from ever meeting a full FIFO
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // A grant and a send in the same cycle cancel out
            case ({out_credit, pop})
                2'b10: begin
                    if (out_credits != '1) begin
                        out_credits <= out_credits + 1'b1;
                    end
                end
                2'b01:   out_credits <= out_credits - 1'b1;
                default: out_credits <= out_credits;
            endcase
        end
    end

endmodule

/* logic/masked_bfu_top.sv */
// Top level of the masked butterfly: randomness, add/sub pipeline, valid tracking and result FIFO
`timescale 1ns/1ps

module masked_bfu_top #(
    parameter int FIFO_DEPTH = 8,
    parameter int WIDTH      = ntt_masked_pkg::SHARE_WIDTH
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  ntt_masked_pkg::bfu_req_t in_req,
    output logic                     in_credit,
    input  logic                     out_credit,
    output logic                     out_valid,
    output ntt_masked_pkg::bfu_rsp_t out_rsp
);

    import ntt_masked_pkg::*;

    // Clocks from request to reduced result
    localparam int LATENCY = 7;

    mask_rnd_t          rnd;
    masked_word_t       bfu_res;
    bfu_rsp_t           wr_rsp;
    logic [LATENCY-1:0] vld_sr;

    // ========================================
    // Valid tracking
    // ========================================

    // The butterfly has no handshake, so this shift register follows each request
    // down the pipe and its top bit lines up with the reduced result
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[LATENCY-2:0], in_valid};
        end
    end

    assign wr_rsp.result = bfu_res;

    mask_rnd_source u_rnd (
        .clk (clk),
        .rst (rst),
        .rnd (rnd)
    );

    masked_bfu_add_sub #(
        .WIDTH(WIDTH)
    ) u_bfu (
        .clk (clk),
        .rst (rst),
        .req (in_req),
        .rnd (rnd),
        .res (bfu_res)
    );

    // Results are written in the cycle the top valid bit is set
    bfu_result_buffer #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_buf (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (vld_sr[LATENCY-1]),
        .wr_rsp     (wr_rsp),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp),
        .in_credit  (in_credit)
    );

endmodule

/* tb/bfu_flow_chk.sv */
// Credit and valid assertions for the masked butterfly top level, attached to it with bind
`timescale 1ns/1ps

module bfu_flow_chk #(
    parameter int FIFO_DEPTH = 8
) (
    input logic clk,
    input logic rst,
    input logic out_valid,
    input logic in_credit,
    input logic out_credit,
    input logic wr_en
);

    // Number of failed assertions, read by the testbench at the end of the run
    int fail_count = 0;

    // Mirrors of the downstream credits and the FIFO fill, kept apart from the RTL counters
    int credits;
    int occupancy;

    always @(posedge clk) begin
        if (rst) begin
            credits   <= 0;
            occupancy <= 0;
        end else begin
            credits   <= credits + int'(out_credit) - int'(out_valid);
            occupancy <= occupancy + int'(wr_en) - int'(out_valid);
        end
    end

    // ========================================
    // Flow rules
    // ========================================

    // A result may only leave while downstream has granted room for it
    a_send_needs_credit: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> credits > 0)
        else begin
            $error("out_valid asserted with no output credit");
            fail_count++;
        end

    // Once reset has been seen for a full clock both strobes are low
    a_quiet_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!out_valid && !in_credit))
        else begin
            $error("out_valid or in_credit high during reset");
            fail_count++;
        end

    // Each pop frees one slot that really held a result
    // The credit pulse goes with that send and with no other cycle
    a_credit_with_send: assert property (@(posedge clk) disable iff (rst)
        (in_credit == out_valid) && (!out_valid || occupancy > 0))
        else begin
            $error("in_credit without a matching send of a held result");
            fail_count++;
        end

    // Upstream credits are meant to keep the FIFO from overfilling
    a_fill_in_range: assert property (@(posedge clk) disable iff (rst)
        occupancy <= FIFO_DEPTH)
        else begin
            $error("FIFO holds more results than its depth");
            fail_count++;
        end

endmodule

/* tb/bfu_scoreboard.sv */
// Scoreboard for the masked butterfly: queues expected values on input and checks each result
`timescale 1ns/1ps

module bfu_scoreboard #(
    parameter int WIDTH = ntt_masked_pkg::SHARE_WIDTH
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  ntt_masked_pkg::bfu_req_t in_req,
    input  logic [WIDTH-1:0]         exp_value,
    input  logic                     out_valid,
    input  ntt_masked_pkg::bfu_rsp_t out_rsp,
    output int                       err_count,
    output int                       result_count
);

    import ntt_masked_pkg::*;

    // Expected values in input order, results must come back in the same order
    logic [WIDTH-1:0] exp_q[$];

    // Last checked result, for the share refresh check
    logic [WIDTH-1:0] prev_exp;
    logic [WIDTH-1:0] prev_share0;
    logic             have_prev;

    // Value the request stands for, by the rule (u+v) mod q or (u-v) mod q
    // Operands are taken as share sums modulo 2^WIDTH and are below q
    function automatic logic [WIDTH-1:0] op_value(input bfu_req_t req);
        logic [WIDTH-1:0] q;
        logic [WIDTH-1:0] u;
        logic [WIDTH-1:0] v;
        q = WIDTH'(MLDSA_Q);
        u = req.u.share0 + req.u.share1;
        v = req.v.share0 + req.v.share1;
        if (req.op == BFU_SUB) begin
            if (u >= v) begin
                return u - v;
            end
            return (u + q) - v;
        end
        if (u + v >= q) begin
            return u + v - q;
        end
        return u + v;
    endfunction

    // ========================================
    // Input capture and result compare
    // ========================================

    always @(posedge clk) begin : compare
        logic [WIDTH-1:0] got;
        logic [WIDTH-1:0] want;
        if (rst) begin
            exp_q.delete();
            err_count    <= 0;
            result_count <= 0;
            have_prev    <= 1'b0;
        end else begin
            if (in_valid) begin
                // The data file and the rule must tell the same story
                if (op_value(in_req) != exp_value) begin
                    $display("stimulus expects %h but the operands give %h at %0t",
                             exp_value, op_value(in_req), $time);
                    err_count <= err_count + 1;
                end
                exp_q.push_back(exp_value);
            end
            if (out_valid) begin
                got = out_rsp.result.share0 + out_rsp.result.share1;
                result_count <= result_count + 1;
                if (exp_q.size() == 0) begin
                    $display("a result came out at %0t with no request outstanding", $time);
                    err_count <= err_count + 1;
                end else begin
                    want = exp_q.pop_front();
                    if (got !== want) begin
                        $display("FAIL %0t out_rsp expected %h got %h", $time, want, got);
                        err_count <= err_count + 1;
                    end else if (have_prev && want == prev_exp
                                 && out_rsp.result.share0 == prev_share0) begin
                        // Equal values must still come back under new masks
                        $display("two equal results at %0t carry the same share0 %h",
                                 $time, prev_share0);
                        err_count <= err_count + 1;
                    end
                    prev_exp    <= want;
                    prev_share0 <= out_rsp.result.share0;
                    have_prev   <= 1'b1;
                end
            end
        end
    end

endmodule

/* tb/tb_masked_bfu.sv */
// Testbench top for the masked butterfly: clock, reset, file stimulus and both credit neighbours
`timescale 1ns/1ps

module tb_masked_bfu;

    import ntt_masked_pkg::*;

    localparam int    FIFO_DEPTH   = 8;
    localparam int    WIDTH        = SHARE_WIDTH;
    localparam int    RESET_CYCLES = 10;
    localparam int    STALL_CYCLES = 50;
    localparam int    WAIT_LIMIT   = 2000;
    localparam int    MAX_LINES    = 64;
    localparam string STIM_FILE    = "tb/bfu_stimulus.txt";

    // How the downstream neighbour hands out credits
    typedef enum {GRANT_NONE, GRANT_RANDOM, GRANT_ALL} grant_mode_e;

    logic             clk = 1'b0;
    logic             rst;
    logic             in_valid;
    bfu_req_t         in_req;
    logic             in_credit;
    logic             out_credit;
    logic             out_valid;
    bfu_rsp_t         out_rsp;
    logic [WIDTH-1:0] exp_value;

    // Stimulus loaded from the data file
    bfu_req_t         req_mem [MAX_LINES];
    logic [WIDTH-1:0] exp_mem [MAX_LINES];
    int               test_mem [MAX_LINES];
    int               num_lines;
    int               line_idx;

    // Neighbour state and bookkeeping
    grant_mode_e grant_mode;
    logic [31:0] lfsr_state;
    int          up_credits;
    int          down_credits;
    int          in_flight;
    int          sb_errors;
    int          sb_results;
    int          drive_errors;
    int          flow_errors;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;

    always #5 clk = ~clk;

    masked_bfu_top #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .WIDTH     (WIDTH)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp)
    );

    bfu_scoreboard #(
        .WIDTH(WIDTH)
    ) u_sb (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_req       (in_req),
        .exp_value    (exp_value),
        .out_valid    (out_valid),
        .out_rsp      (out_rsp),
        .err_count    (sb_errors),
        .result_count (sb_results)
    );

    // The checker sees the top level's own view of the FIFO write
    bind masked_bfu_top bfu_flow_chk #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_flow_chk (
        .clk        (clk),
        .rst        (rst),
        .out_valid  (out_valid),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .wr_en      (vld_sr[LATENCY-1])
    );

    // Fibonacci LFSR step, taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "add";
            2:       return "sub";
            3:       return "masking";
            4:       return "back-pressure";
            5:       return "streaming";
            default: return "other";
        endcase
    endfunction

    function automatic int error_total();
        return sb_errors + drive_errors + flow_errors + dut.u_flow_chk.fail_count;
    endfunction

    // ========================================
    // Credit bookkeeping of both neighbours
    // ========================================

    always @(posedge clk) begin
        if (rst) begin
            up_credits   <= FIFO_DEPTH;
            down_credits <= 0;
            in_flight    <= 0;
        end else begin
            up_credits   <= up_credits - int'(in_valid) + int'(in_credit);
            down_credits <= down_credits + int'(out_credit) - int'(out_valid);
            in_flight    <= in_flight + int'(in_valid) - int'(out_valid);
            if (in_credit && (up_credits - int'(in_valid) + 1) > FIFO_DEPTH) begin
                $display("in_credit at %0t returns more credits than the FIFO has slots", $time);
                flow_errors <= flow_errors + 1;
            end
        end
    end

    // Downstream never grants more credits than results it still expects,
    // so a drained DUT holds none
    always @(negedge clk) begin
        logic grant;
        grant = 1'b0;
        if (!rst && down_credits < in_flight) begin
            case (grant_mode)
                GRANT_ALL: grant = 1'b1;
                GRANT_RANDOM: begin
                    lfsr_state = lfsr_next(lfsr_state);
                    grant      = lfsr_state[0];
                end
                default: grant = 1'b0;
            endcase
        end
        out_credit = grant;
    end

    // ========================================
    // Stimulus tasks
    // ========================================

    task automatic load_stimulus();
        int               fd;
        int               id;
        int               op;
        string            text;
        logic [WIDTH-1:0] u0;
        logic [WIDTH-1:0] u1;
        logic [WIDTH-1:0] v0;
        logic [WIDTH-1:0] v1;
        logic [WIDTH-1:0] ev;
        num_lines = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file %s", STIM_FILE);
            return;
        end
        while ($fgets(text, fd) != 0 && num_lines < MAX_LINES) begin
            // Comment lines start with a hash
            if (text.len() > 1 && text[0] != "#") begin
                if ($sscanf(text, "%d %d %h %h %h %h %h", id, op, u0, u1, v0, v1, ev) == 7) begin
                    test_mem[num_lines]        = id;
                    req_mem[num_lines].op       = (op != 0) ? BFU_SUB : BFU_ADD;
                    req_mem[num_lines].u.share0 = u0;
                    req_mem[num_lines].u.share1 = u1;
                    req_mem[num_lines].v.share0 = v0;
                    req_mem[num_lines].v.share1 = v1;
                    exp_mem[num_lines]         = ev;
                    num_lines++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Issues one request on the falling edge once upstream holds a credit
    task automatic send_req(input int idx);
        int waited;
        waited = 0;
        while (up_credits == 0 && !timed_out) begin
            in_valid = 1'b0;
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: no input credit came back within %0d cycles", WAIT_LIMIT);
                timed_out = 1'b1;
            end
        end
        if (!timed_out) begin
            in_valid  = 1'b1;
            in_req    = req_mem[idx];
            exp_value = exp_mem[idx];
            @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (in_flight != 0 && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: %0d results still missing after %0d cycles",
                         in_flight, WAIT_LIMIT);
                timed_out = 1'b1;
            end
        end
    endtask

    // With no grants the FIFO fills and nothing may leave
    task automatic check_stall();
        for (int cyc = 0; cyc < STALL_CYCLES; cyc++) begin
            @(negedge clk);
            if (out_valid) begin
                $display("out_valid high at %0t although downstream granted no credit", $time);
                drive_errors++;
            end
        end
        if (up_credits != 0) begin
            $display("upstream got %0d credits back while the FIFO was stalled", up_credits);
            drive_errors++;
        end
    endtask

    // Runs all lines that share the test id at line_idx
    task automatic run_test();
        int id;
        int sent;
        int errs_before;
        id          = test_mem[line_idx];
        sent        = 0;
        errs_before = error_total();
        grant_mode  = (id == 4) ? GRANT_NONE : ((id == 5) ? GRANT_ALL : GRANT_RANDOM);
        while (line_idx < num_lines && test_mem[line_idx] == id && !timed_out) begin
            send_req(line_idx);
            line_idx++;
            sent++;
        end
        in_valid = 1'b0;
        if (id == 4 && !timed_out) begin
            check_stall();
            grant_mode = GRANT_RANDOM;
        end
        wait_drain();
        tests_run++;
        if (error_total() != errs_before || timed_out) begin
            tests_failed++;
            $display("test %0d %s: %0d operations, failed", id, test_name(id), sent);
        end else begin
            $display("test %0d %s: %0d operations, passed", id, test_name(id), sent);
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_req       = '0;
        exp_value    = '0;
        out_credit   = 1'b0;
        grant_mode   = GRANT_NONE;
        lfsr_state   = 32'h2213;
        drive_errors = 0;
        flow_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        line_idx     = 0;
        load_stimulus();
        if (num_lines == 0) begin
            $display("no stimulus lines were loaded");
            drive_errors++;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        while (line_idx < num_lines && !timed_out) begin
            run_test();
        end
        $display("%0d tests, %0d failed, %0d results checked, %0d errors",
                 tests_run, tests_failed, sb_results, error_total());
        if (error_total() == 0 && !timed_out && num_lines > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* tb/bfu_stimulus.txt */
# Columns: test id, op (0 add, 1 sub), u share0, u share1, v share0, v share1, expected (hex)
# Tests: 1 add, 2 sub, 3 masking, 4 back-pressure, 5 streaming
1 0 7FE000 0 0 0 7FE000
1 0 7FD100 3FFFFFFFFF00 1001 0 0
1 0 1234D6589A 3FEDCBA98766 7FE100 3FFFFFFFFF00 7FDFFF
1 0 123456 0 654321 0 777777
1 0 400100 3FFFFFFFFF00 3FF000 0 FFF
1 0 123456789A 3FEDCBA98766 123456789A 3FEDCBA98766 0
2 1 345678 0 345778 3FFFFFFFFF00 0
2 1 500000 0 100000 0 400000
2 1 1 0 2 0 7FE000
2 1 123456789A 3FEDCBA98766 7FE000 0 1
2 1 100100 3FFFFFFFFF00 1234C6789A 3FEDCBA98766 1FE001
3 0 2AAAAA 0 155555 0 3FFFFF
3 0 2AABAA 3FFFFFFFFF00 155655 3FFFFFFFFF00 3FFFFF
3 0 1234812344 3FEDCBA98766 12346BCDEF 3FEDCBA98766 3FFFFF
3 0 2AAAAA 0 12346BCDEF 3FEDCBA98766 3FFFFF
4 0 1 0 2 0 3
4 1 10 0 1 0 F
4 0 7FE000 0 2 0 1
4 1 0 0 1 0 7FE000
4 0 100100 3FFFFFFFFF00 100000 0 200000
4 1 200000 0 100100 3FFFFFFFFF00 100000
4 0 7FE000 0 7FE000 0 7FDFFF
4 1 7FE000 0 0 0 7FE000
5 0 111111 0 222222 0 333333
5 1 333333 0 111111 0 222222
5 0 600000 0 300000 0 101FFF

/* files.f */
logic/ntt_masked_pkg.sv
logic/masked_share_adder.sv
logic/masked_mod_reduce.sv
logic/masked_bfu_add_sub.sv
logic/mask_rnd_source.sv
logic/bfu_result_buffer.sv
logic/masked_bfu_top.sv
tb/bfu_flow_chk.sv
tb/bfu_scoreboard.sv
tb/tb_masked_bfu.sv

/* Bender.yml */
package:
  name: masked_bfu

sources:
  - files:
      - logic/ntt_masked_pkg.sv
      - logic/masked_share_adder.sv
      - logic/masked_mod_reduce.sv
      - logic/masked_bfu_add_sub.sv
      - logic/mask_rnd_source.sv
      - logic/bfu_result_buffer.sv
      - logic/masked_bfu_top.sv
  - target: test
    files:
      - tb/bfu_flow_chk.sv
      - tb/bfu_scoreboard.sv
      - tb/tb_masked_bfu.sv
